//--- compile.f
+incdir+sim
hw/pit_bus_pkg.sv
hw/pit_count_pkg.sv
hw/pit_clock_sync.sv
hw/pit_bus_decode.sv
hw/timer_unit.sv
hw/pit.sv
sim/pit_tb.sv

//--- hw/pit.sv
// Three-channel programmable interval timer
// Connects the port decoder, the input synchronizer and the channels
`timescale 1ns/1ps
`default_nettype none

module pit (
    input  logic                    reset,
    input  logic                    clk,
    input  logic                    cs,
    input  pit_bus_pkg::port_addr_t addr,
    input  logic                    wr,
    input  logic                    rd,
    input  pit_bus_pkg::bus_byte_t  wr_data,
    output pit_bus_pkg::bus_byte_t  rd_data,
    output logic                    rd_valid,
    input  logic                    pit_clk,
    input  logic [2:0]              gate,
    output logic [2:0]              out
);

    logic                       pit_tick;
    logic [2:0]                 gate_level;
    logic [2:0]                 gate_rise;
    logic [2:0]                 configure;
    logic [2:0]                 latch_count;
    logic [2:0]                 load;
    logic [2:0]                 read_count;
    pit_count_pkg::count_mode_e mode_in;
    pit_bus_pkg::rw_mode_t      rw_in;
    pit_bus_pkg::bus_byte_t     reload_in;
    pit_bus_pkg::bus_byte_t     count_out0;
    pit_bus_pkg::bus_byte_t     count_out1;
    pit_bus_pkg::bus_byte_t     count_out2;

    pit_clock_sync i_clock_sync (
        .reset      (reset),
        .clk        (clk),
        .pit_clk    (pit_clk),
        .gate       (gate),
        .pit_tick   (pit_tick),
        .gate_level (gate_level),
        .gate_rise  (gate_rise)
    );

    pit_bus_decode i_bus_decode (
        .reset       (reset),
        .clk         (clk),
        .cs          (cs),
        .addr        (addr),
        .wr          (wr),
        .rd          (rd),
        .wr_data     (wr_data),
        .configure   (configure),
        .latch_count (latch_count),
        .load        (load),
        .read_count  (read_count),
        .mode_in     (mode_in),
        .rw_in       (rw_in),
        .reload_in   (reload_in),
        .count_out0  (count_out0),
        .count_out1  (count_out1),
        .count_out2  (count_out2),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid)
    );

    // All channels share the tick and the decoded write data
    timer_unit i_timer0 (
        .reset       (reset),
        .clk         (clk),
        .pit_tick    (pit_tick),
        .gate_level  (gate_level[0]),
        .gate_rise   (gate_rise[0]),
        .load        (load[0]),
        .reload_in   (reload_in),
        .configure   (configure[0]),
        .mode_in     (mode_in),
        .rw_in       (rw_in),
        .latch_count (latch_count[0]),
        .read_count  (read_count[0]),
        .count_out   (count_out0),
        .out         (out[0])
    );

    timer_unit i_timer1 (
        .reset       (reset),
        .clk         (clk),
        .pit_tick    (pit_tick),
        .gate_level  (gate_level[1]),
        .gate_rise   (gate_rise[1]),
        .load        (load[1]),
        .reload_in   (reload_in),
        .configure   (configure[1]),
        .mode_in     (mode_in),
        .rw_in       (rw_in),
        .latch_count (latch_count[1]),
        .read_count  (read_count[1]),
        .count_out   (count_out1),
        .out         (out[1])
    );

    timer_unit i_timer2 (
        .reset       (reset),
        .clk         (clk),
        .pit_tick    (pit_tick),
        .gate_level  (gate_level[2]),
        .gate_rise   (gate_rise[2]),
        .load        (load[2]),
        .reload_in   (reload_in),
        .configure   (configure[2]),
        .mode_in     (mode_in),
        .rw_in       (rw_in),
        .latch_count (latch_count[2]),
        .read_count  (read_count[2]),
        .count_out   (count_out2),
        .out         (out[2])
    );

endmodule

`default_nettype wire

//--- hw/pit_bus_decode.sv
// Interval timer port decoder
// Turns processor accesses into channel strobes and registers read data
`timescale 1ns/1ps
`default_nettype none

module pit_bus_decode (
    input  logic                                      reset,
    input  logic                                      clk,
    input  logic                                      cs,
    input  pit_bus_pkg::port_addr_t                   addr,
    input  logic                                      wr,
    input  logic                                      rd,
    input  pit_bus_pkg::bus_byte_t                    wr_data,
    output logic [pit_bus_pkg::NUM_CHANNELS-1:0]      configure,
    output logic [pit_bus_pkg::NUM_CHANNELS-1:0]      latch_count,
    output logic [pit_bus_pkg::NUM_CHANNELS-1:0]      load,
    output logic [pit_bus_pkg::NUM_CHANNELS-1:0]      read_count,
    output pit_count_pkg::count_mode_e                mode_in,
    output pit_bus_pkg::rw_mode_t                     rw_in,
    output pit_bus_pkg::bus_byte_t                    reload_in,
    input  pit_bus_pkg::bus_byte_t                    count_out0,
    input  pit_bus_pkg::bus_byte_t                    count_out1,
    input  pit_bus_pkg::bus_byte_t                    count_out2,
    output pit_bus_pkg::bus_byte_t                    rd_data,
    output logic                                      rd_valid
);

    logic [1:0]             cw_sel;
    logic                   ctrl_write;
    logic                   data_write;
    logic                   data_read;
    pit_bus_pkg::bus_byte_t read_byte;

    assign cw_sel = wr_data[pit_bus_pkg::CW_SEL_HI:pit_bus_pkg::CW_SEL_LO];

    assign ctrl_write = cs && wr && (addr == pit_bus_pkg::ADDR_CTRL);
    assign data_write = cs && wr && (addr != pit_bus_pkg::ADDR_CTRL);
    assign data_read  = cs && rd && (addr != pit_bus_pkg::ADDR_CTRL);

    // Mode and access fields go to every channel, only the strobe selects one
    assign rw_in = wr_data[pit_bus_pkg::CW_RW_HI:pit_bus_pkg::CW_RW_LO];

    // The top mode bit is dropped so that modes 6 and 7 alias 2 and 3
    assign mode_in = pit_count_pkg::count_mode_e'(
        wr_data[pit_bus_pkg::CW_MODE_HI-1:pit_bus_pkg::CW_MODE_LO]);

    assign reload_in = wr_data;

    always_comb begin
        configure   = '0;
        latch_count = '0;
        load        = '0;
        read_count  = '0;
        // Channel select 3 is the read-back command, which is not supported
        if (ctrl_write && (cw_sel < pit_bus_pkg::NUM_CHANNELS)) begin
            if (rw_in == pit_bus_pkg::RW_LATCH) begin
                latch_count[cw_sel] = 1'b1;
            end else begin
                configure[cw_sel] = 1'b1;
            end
        end
        if (data_write) begin
            load[addr] = 1'b1;
        end
        if (data_read) begin
            read_count[addr] = 1'b1;
        end
    end

    // Channels present their next byte combinationally
    always_comb begin
        case (addr)
            2'd0:    read_byte = count_out0;
            2'd1:    read_byte = count_out1;
            2'd2:    read_byte = count_out2;
            default: read_byte = '0;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cs && rd;
        end
    end

    // Read data is captured in the same cycle as the read strobe
    always_ff @(posedge reset) begin
        if (cs && rd) begin
            rd_data <= read_byte;
        end
    end

endmodule

`default_nettype wire

//--- hw/pit_bus_pkg.sv
// Processor port definitions of the interval timer
// Covers port addresses, access codes and the control word layout
`default_nettype none

package pit_bus_pkg;

    // Three counter channels sit behind the port interface
    localparam int NUM_CHANNELS = 3;

    // Port address, where 0 to 2 select a channel and 3 the control word
    typedef logic [1:0] port_addr_t;

    // One byte on the data bus
    typedef logic [7:0] bus_byte_t;

    // Access mode carried in the control word
    typedef logic [1:0] rw_mode_t;

    localparam port_addr_t ADDR_CTRL = 2'd3;

    // Code 0 is not a real access mode but the counter latch command
    localparam rw_mode_t RW_LATCH = 2'd0;
    localparam rw_mode_t RW_LSB   = 2'd1;
    localparam rw_mode_t RW_MSB   = 2'd2;
    localparam rw_mode_t RW_BOTH  = 2'd3;

    // Control word bit positions
    localparam int CW_SEL_HI  = 7;
    localparam int CW_SEL_LO  = 6;
    localparam int CW_RW_HI   = 5;
    localparam int CW_RW_LO   = 4;
    localparam int CW_MODE_HI = 3;
    localparam int CW_MODE_LO = 1;

endpackage

`default_nettype wire

//--- hw/pit_clock_sync.sv
// Interval timer input synchronizer
// Turns pit_clk and the gate inputs into system clock pulses and levels
`timescale 1ns/1ps
`default_nettype none

module pit_clock_sync (
    input  logic       reset,
    input  logic       clk,
    input  logic       pit_clk,
    input  logic [2:0] gate,
    output logic       pit_tick,
    output logic [2:0] gate_level,
    output logic [2:0] gate_rise
);

    logic [1:0] pit_sync;
    logic       pit_last;
    logic [2:0] gate_meta;
    logic [2:0] gate_last;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pit_sync   <= 2'b00;
            pit_last   <= 1'b0;
            pit_tick   <= 1'b0;
            gate_meta  <= 3'b000;
            gate_level <= 3'b000;
            gate_last  <= 3'b000;
            gate_rise  <= 3'b000;
        end else begin
            // Two flops bring the slow counting clock into this domain
            pit_sync <= {pit_sync[0], pit_clk};
            pit_last <= pit_sync[1];
            // One tick per rising pit_clk, shared by all channels
            pit_tick <= pit_sync[1] & ~pit_last;

            gate_meta  <= gate;
            gate_level <= gate_meta;
            gate_last  <= gate_level;
            // A rising gate restarts the count of its channel
            gate_rise  <= gate_level & ~gate_last;
        end
    end

endmodule

`default_nettype wire

//--- hw/pit_count_pkg.sv
// Counter definitions of the interval timer
// Covers the count width, the counting modes and the terminal values
`default_nettype none

package pit_count_pkg;

    // Counter, reload and latched values are all 16 bits wide
    typedef logic [15:0] count_t;

    // Low two bits of the control word mode field
    // Modes 0 and 1 are not supported and leave the channel idle
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_IDLE1  = 2'd1,
        MODE_RATE   = 2'd2,
        MODE_SQUARE = 2'd3
    } count_mode_e;

    // Cleared count and reload value
    localparam count_t COUNT_CLEAR = 16'h0000;

    // Count at which the rate generator drives out low and then reloads
    localparam count_t COUNT_TERMINAL = 16'h0001;

    // A reload of zero stands for the longest period
    localparam count_t RELOAD_ZERO_VALUE = 16'hFFFF;

endpackage

`default_nettype wire

//--- hw/timer_unit.sv
// Interval timer channel
// A 16-bit down counter with byte access, count latch and two waveforms
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
    input  logic                       reset,
    input  logic                       clk,
    input  logic                       pit_tick,
    input  logic                       gate_level,
    input  logic                       gate_rise,
    input  logic                       load,
    input  pit_bus_pkg::bus_byte_t     reload_in,
    input  logic                       configure,
    input  pit_count_pkg::count_mode_e mode_in,
    input  pit_bus_pkg::rw_mode_t      rw_in,
    input  logic                       latch_count,
    input  logic                       read_count,
    output pit_bus_pkg::bus_byte_t     count_out,
    output logic                       out
);

    pit_count_pkg::count_mode_e mode;
    pit_bus_pkg::rw_mode_t      rw;
    pit_count_pkg::count_t      count;
    pit_count_pkg::count_t      reload;
    pit_count_pkg::count_t      latched_count;
    pit_count_pkg::count_t      load_value;
    pit_count_pkg::count_t      new_reload;
    pit_count_pkg::count_t      half_reload;
    pit_count_pkg::count_t      read_source;
    pit_bus_pkg::bus_byte_t     reload_low;
    logic                       write_msb;
    logic                       read_msb;
    logic                       latch_valid;
    logic                       armed;
    logic                       pending;
    logic                       counting;
    logic                       loading;
    logic                       load_done;
    logic                       tick_en;

    // Only the rate generator and square wave modes count
    assign counting = (mode == pit_count_pkg::MODE_RATE) ||
                      (mode == pit_count_pkg::MODE_SQUARE);

    // A channel that was never configured ignores data writes
    assign loading = load && (rw != pit_bus_pkg::RW_LATCH);

    // In low-then-high mode the reload completes with the second byte
    assign load_done = loading && ((rw != pit_bus_pkg::RW_BOTH) || write_msb);

    assign tick_en = pit_tick && gate_level && armed && counting;

    // Single byte modes clear the other half of the reload
    always_comb begin
        case (rw)
            pit_bus_pkg::RW_LSB: load_value = {8'h00, reload_in};
            pit_bus_pkg::RW_MSB: load_value = {reload_in, 8'h00};
            default:             load_value = {reload_in, reload_low};
        endcase
    end

    assign new_reload = (load_value == pit_count_pkg::COUNT_CLEAR) ?
                        pit_count_pkg::RELOAD_ZERO_VALUE : load_value;

    // Square wave stays high while the count is above half the reload
    assign half_reload = {1'b0, reload[15:1]};

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            mode <= pit_count_pkg::MODE_IDLE;
            rw   <= pit_bus_pkg::RW_LATCH;
        end else if (configure) begin
            mode <= mode_in;
            rw   <= rw_in;
        end
    end

    // Reload register and the write byte pointer
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            reload    <= pit_count_pkg::COUNT_CLEAR;
            write_msb <= 1'b0;
        end else if (configure) begin
            reload    <= pit_count_pkg::COUNT_CLEAR;
            write_msb <= 1'b0;
        end else if (load_done) begin
            reload    <= new_reload;
            write_msb <= 1'b0;
        end else if (loading) begin
            // First byte of a low-then-high pair
            write_msb <= 1'b1;
        end
    end

    always_ff @(posedge reset) begin
        if (loading && !write_msb) begin
            reload_low <= reload_in;
        end
    end

    // Down counter
    // After a configure the channel waits for a complete reload before counting
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            count   <= pit_count_pkg::COUNT_CLEAR;
            armed   <= 1'b0;
            pending <= 1'b0;
        end else if (configure) begin
            armed   <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (load_done) begin
                armed <= 1'b1;
            end
            // A new reload or a gate rise restarts the count on the next tick
            if (load_done || gate_rise) begin
                pending <= 1'b1;
            end else if (tick_en) begin
                pending <= 1'b0;
            end
            if (load_done) begin
                // Shows the new value at once so that an early latch sees it
                count <= new_reload;
            end else if (tick_en) begin
                if (pending || (count <= pit_count_pkg::COUNT_TERMINAL)) begin
                    count <= reload;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // Count latch and read byte pointer
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            latched_count <= pit_count_pkg::COUNT_CLEAR;
            latch_valid   <= 1'b0;
            read_msb      <= 1'b0;
        end else if (configure) begin
            latch_valid <= 1'b0;
            read_msb    <= 1'b0;
        end else if (latch_count && !latch_valid) begin
            // Further latches are ignored until the held value is read
            latched_count <= count;
            latch_valid   <= 1'b1;
            read_msb      <= 1'b0;
        end else if (read_count) begin
            if (rw == pit_bus_pkg::RW_BOTH) begin
                read_msb <= ~read_msb;
            end
            // The latch is released once its last byte has gone out
            if ((rw != pit_bus_pkg::RW_BOTH) || read_msb) begin
                latch_valid <= 1'b0;
            end
        end
    end

    assign read_source = latch_valid ? latched_count : count;

    always_comb begin
        case (rw)
            pit_bus_pkg::RW_MSB:  count_out = read_source[15:8];
            pit_bus_pkg::RW_BOTH: count_out = read_msb ? read_source[15:8] :
                                                         read_source[7:0];
            default:              count_out = read_source[7:0];
        endcase
    end

    // Output follows the count one cycle later
    // It is held high whenever the channel is not counting
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            out <= 1'b1;
        end else if (!counting || !armed || !gate_level || pending) begin
            out <= 1'b1;
        end else if (mode == pit_count_pkg::MODE_RATE) begin
            out <= (count != pit_count_pkg::COUNT_TERMINAL);
        end else begin
            out <= (count > half_reload);
        end
    end

endmodule

`default_nettype wire

//--- sim/pit_tb_tasks.svh
// Interval timer testbench tasks
// Bus write and read cycles and measurement of a channel's out waveform
`ifndef PIT_TB_TASKS_SVH
`define PIT_TB_TASKS_SVH

// Drives one write cycle and releases the strobes on the next edge
task automatic bus_write(input pit_bus_pkg::port_addr_t a, input pit_bus_pkg::bus_byte_t d);
    @(posedge reset);
    #1;
    cs      = 1'b1;
    wr      = 1'b1;
    addr    = a;
    wr_data = d;
    @(posedge reset);
    #1;
    cs = 1'b0;
    wr = 1'b0;
endtask

// Drives one read cycle and collects the byte that comes back with rd_valid
task automatic bus_read(input pit_bus_pkg::port_addr_t a, output pit_bus_pkg::bus_byte_t d);
    int waited;
    @(posedge reset);
    #1;
    cs   = 1'b1;
    rd   = 1'b1;
    addr = a;
    @(posedge reset);
    #1;
    cs     = 1'b0;
    rd     = 1'b0;
    waited = 0;
    while (!rd_valid && (waited < 4)) begin
        @(posedge reset);
        #1;
        waited++;
    end
    if (!rd_valid) begin
        error_count++;
        $display("ERROR: no rd_valid came back after a read of address %0d", a);
    end
    d = rd_data;
endtask

// Out settles well inside a pit_clk period, so the rising pit_clk is a quiet point
task automatic sample_out(input int ch, output logic level);
    @(posedge pit_clk);
    level = out[ch];
endtask

// Finds a falling edge of out, then times low and high runs in pit_clk periods
task automatic measure_wave(input string name, input int ch, input int exp_high,
                            input int exp_low, input int periods);
    logic prev;
    logic cur;
    int   limit;
    int   waited;
    int   low_run;
    int   high_run;
    limit  = 2 * (exp_high + exp_low) + 8;
    waited = 0;
    sample_out(ch, prev);
    sample_out(ch, cur);
    while (!(prev && !cur) && (waited < limit)) begin
        prev = cur;
        sample_out(ch, cur);
        waited++;
    end
    if (!(prev && !cur)) begin
        error_count++;
        $display("ERROR: %s out on channel %0d never went low", name, ch);
        return;
    end
    for (int p = 0; p < periods; p++) begin
        low_run  = 0;
        high_run = 0;
        while (!cur && (low_run < limit)) begin
            low_run++;
            sample_out(ch, cur);
        end
        while (cur && (high_run < limit)) begin
            high_run++;
            sample_out(ch, cur);
        end
        check_count++;
        if (low_run != exp_low) begin
            error_count++;
            $display("FAIL %s: low ticks expected %0d, actual %0d", name, exp_low, low_run);
        end
        check_count++;
        if (high_run != exp_high) begin
            error_count++;
            $display("FAIL %s: high ticks expected %0d, actual %0d", name, exp_high, high_run);
        end
    end
endtask

`endif

//--- sim/pit_tb.sv
// Interval timer testbench
// Applies a table of channel setups and checks waveforms, latched counts and gating
`timescale 1ns/1ps
`default_nettype none

module pit_tb;

    localparam int NUM_TESTS     = 11;
    localparam int PIT_PERIOD_NS = 80;

    // What the loop does with an entry besides the waveform check
    localparam int PAT_RUN   = 0;
    localparam int PAT_LATCH = 1;
    localparam int PAT_GATE  = 2;
    localparam int PAT_ZERO  = 3;

    logic                    reset;
    logic                    clk;
    logic                    cs;
    logic                    wr;
    logic                    rd;
    pit_bus_pkg::port_addr_t addr;
    pit_bus_pkg::bus_byte_t  wr_data;
    pit_bus_pkg::bus_byte_t  rd_data;
    logic                    rd_valid;
    logic                    pit_clk;
    logic [2:0]              gate;
    logic [2:0]              out;

    string                      t_name    [NUM_TESTS];
    int                         t_chan    [NUM_TESTS];
    pit_count_pkg::count_mode_e t_mode    [NUM_TESTS];
    pit_bus_pkg::rw_mode_t      t_rw      [NUM_TESTS];
    pit_count_pkg::count_t      t_reload  [NUM_TESTS];
    int                         t_pattern [NUM_TESTS];
    int                         t_high    [NUM_TESTS];
    int                         t_low     [NUM_TESTS];

    int          error_count = 0;
    int          check_count = 0;
    logic        table_ready = 1'b0;
    longint      watchdog_ns;
    pit_bus_pkg::bus_byte_t reset_byte;

    pit i_dut (
        .reset    (reset),
        .clk      (clk),
        .cs       (cs),
        .addr     (addr),
        .wr       (wr),
        .rd       (rd),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .pit_clk  (pit_clk),
        .gate     (gate),
        .out      (out)
    );

    `include "pit_tb_tasks.svh"

    // The system clock port of the DUT is named reset
    always #5 reset = ~reset;

    // Counting clock at one eighth of the system clock, moved just after an edge
    always begin
        repeat (4) @(posedge reset);
        #1;
        pit_clk = ~pit_clk;
    end

    task automatic set_entry(input int i, input string name, input int ch,
                             input pit_count_pkg::count_mode_e mode,
                             input pit_bus_pkg::rw_mode_t rw, input pit_count_pkg::count_t n,
                             input int pattern, input int high, input int low);
        t_name[i]    = name;
        t_chan[i]    = ch;
        t_mode[i]    = mode;
        t_rw[i]      = rw;
        t_reload[i]  = n;
        t_pattern[i] = pattern;
        t_high[i]    = high;
        t_low[i]     = low;
    endtask

    // Rate mode is low for one tick per period
    // Square mode is high for (N+1)/2 ticks and low for N/2
    task automatic fill_table();
        set_entry(0, "rate_ch0_n5", 0, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd5, PAT_RUN, 4, 1);
        set_entry(1, "rate_ch1_n8", 1, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd8, PAT_RUN, 7, 1);
        set_entry(2, "rate_ch2_n13", 2, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd13, PAT_RUN, 12, 1);
        set_entry(3, "square_n6", 0, pit_count_pkg::MODE_SQUARE, pit_bus_pkg::RW_BOTH,
                  16'd6, PAT_RUN, 3, 3);
        set_entry(4, "square_n7", 1, pit_count_pkg::MODE_SQUARE, pit_bus_pkg::RW_BOTH,
                  16'd7, PAT_RUN, 4, 3);
        set_entry(5, "square_n10", 2, pit_count_pkg::MODE_SQUARE, pit_bus_pkg::RW_BOTH,
                  16'd10, PAT_RUN, 5, 5);
        set_entry(6, "latch_read_n13", 1, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd13, PAT_LATCH, 12, 1);
        set_entry(7, "gate_low_n8", 2, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd8, PAT_GATE, 7, 1);
        set_entry(8, "lsb_only_n9", 0, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_LSB,
                  16'd9, PAT_RUN, 8, 1);
        set_entry(9, "msb_only_n256", 1, pit_count_pkg::MODE_SQUARE, pit_bus_pkg::RW_MSB,
                  16'd256, PAT_RUN, 128, 128);
        set_entry(10, "zero_reload", 2, pit_count_pkg::MODE_RATE, pit_bus_pkg::RW_BOTH,
                  16'd0, PAT_ZERO, 0, 0);
    endtask

    task automatic write_control(input int ch, input pit_bus_pkg::rw_mode_t rw,
                                 input pit_count_pkg::count_mode_e mode);
        pit_bus_pkg::bus_byte_t cw;
        cw = '0;
        cw[pit_bus_pkg::CW_SEL_HI:pit_bus_pkg::CW_SEL_LO]   = ch[1:0];
        cw[pit_bus_pkg::CW_RW_HI:pit_bus_pkg::CW_RW_LO]     = rw;
        cw[pit_bus_pkg::CW_MODE_HI:pit_bus_pkg::CW_MODE_LO] = {1'b0, mode};
        bus_write(pit_bus_pkg::ADDR_CTRL, cw);
    endtask

    // Sends the reload in the byte order that the access code asks for
    task automatic load_reload(input int ch, input pit_bus_pkg::rw_mode_t rw,
                               input pit_count_pkg::count_t n);
        if (rw != pit_bus_pkg::RW_MSB) begin
            bus_write(ch[1:0], n[7:0]);
        end
        if (rw != pit_bus_pkg::RW_LSB) begin
            bus_write(ch[1:0], n[15:8]);
        end
    endtask

    // Latch command, then the low byte and the high byte
    task automatic latch_and_read(input int ch, output pit_count_pkg::count_t value);
        pit_bus_pkg::bus_byte_t lo;
        pit_bus_pkg::bus_byte_t hi;
        write_control(ch, pit_bus_pkg::RW_LATCH, pit_count_pkg::MODE_IDLE);
        bus_read(ch[1:0], lo);
        bus_read(ch[1:0], hi);
        value = {hi, lo};
    endtask

    task automatic check_range(input string name, input pit_count_pkg::count_t value,
                               input pit_count_pkg::count_t n);
        check_count++;
        if ((value < 16'd1) || (value > n)) begin
            error_count++;
            $display("FAIL %s: latched count expected 1..%0d, actual %0d", name, n, value);
        end
    endtask

    task automatic run_entry(input int i);
        pit_count_pkg::count_t first;
        pit_count_pkg::count_t second;
        logic                  level;
        int                    hold;
        write_control(t_chan[i], t_rw[i], t_mode[i]);
        load_reload(t_chan[i], t_rw[i], t_reload[i]);
        if (t_pattern[i] == PAT_ZERO) begin
            // Zero bytes stand for 65535, and only a few ticks can pass before the latch
            latch_and_read(t_chan[i], first);
            check_count++;
            if (first < 16'hFFF0) begin
                error_count++;
                $display("FAIL %s: count expected at least 16'hfff0, actual %h", t_name[i], first);
            end
            return;
        end
        measure_wave(t_name[i], t_chan[i], t_high[i], t_low[i], 3);
        if (t_pattern[i] == PAT_LATCH) begin
            latch_and_read(t_chan[i], first);
            check_range(t_name[i], first, t_reload[i]);
            // With the gate low the count stands still between two latches
            gate[t_chan[i]] = 1'b0;
            repeat (2) @(posedge pit_clk);
            latch_and_read(t_chan[i], first);
            repeat (2) @(posedge pit_clk);
            latch_and_read(t_chan[i], second);
            check_range(t_name[i], first, t_reload[i]);
            check_count++;
            if (second != first) begin
                error_count++;
                $display("FAIL %s: held count expected %0d, actual %0d", t_name[i], first, second);
            end
            gate[t_chan[i]] = 1'b1;
        end
        if (t_pattern[i] == PAT_GATE) begin
            hold = 3 + ($urandom % 8);
            gate[t_chan[i]] = 1'b0;
            @(posedge pit_clk);
            repeat (hold) begin
                sample_out(t_chan[i], level);
                check_count++;
                if (level !== 1'b1) begin
                    error_count++;
                    $display("FAIL %s: out with gate low expected 1, actual %b", t_name[i], level);
                end
            end
            // The gate rise restarts the count, so the next period is whole again
            gate[t_chan[i]] = 1'b1;
            measure_wave(t_name[i], t_chan[i], t_high[i], t_low[i], 1);
        end
    endtask

    initial begin
        void'($urandom(32'h39b0));
        reset      = 1'b0;
        clk        = 1'b1;
        cs         = 1'b0;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        pit_clk    = 1'b0;
        gate       = 3'b111;
        fill_table();
        // Three periods of every entry, with a zero reload standing for 65535
        watchdog_ns = 20000;
        for (int i = 0; i < NUM_TESTS; i++) begin
            watchdog_ns += ((t_reload[i] == 0) ? 65535 : t_reload[i]) * 3 * PIT_PERIOD_NS;
        end
        table_ready = 1'b1;
        repeat (8) @(posedge reset);
        #1;
        clk = 1'b0;
        check_count++;
        if ((out !== 3'b111) || (rd_valid !== 1'b0)) begin
            error_count++;
            $display("FAIL reset_state: out expected 111, actual %b, rd_valid expected 0, actual %b",
                     out, rd_valid);
        end
        bus_read(2'd0, reset_byte);
        check_count++;
        if (reset_byte !== 8'h00) begin
            error_count++;
            $display("FAIL reset_count: expected 00, actual %h", reset_byte);
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("ERROR: watchdog expired after %0d ns before the tests finished", watchdog_ns);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
